//--- src.f
rtl/alu_pkg.sv
rtl/alu_op_issue.sv
rtl/alu_shifter.sv
rtl/alu_bit_count.sv
rtl/alu_exec.sv
rtl/alu_result_queue.sv
rtl/alu_top.sv
dv/alu_assertions.sv
dv/alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the failure line in the log
rm -rf obj_dir build.log sim.log
verilator --binary --assert --top-module alu_tb -f src.f -o alu_sim > build.log 2>&1 \
  || { cat build.log; exit 1; }
./obj_dir/alu_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "Something failed" sim.log && exit 1 || grep -q "Everything OK" sim.log

//--- dv/alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_tb;

  import alu_pkg::*;

  localparam int unsigned QUEUE_DEPTH = 4;
  localparam int unsigned OUT_CREDITS = 2;
  localparam int unsigned NUM_REQS    = 2000;
  localparam int unsigned TIMEOUT     = 200;

  logic    clk_i;
  logic    rst_n_i;
  logic    req_valid_i;
  alu_op_e req_op_i;
  word_t   req_operand_a_i;
  word_t   req_operand_b_i;
  logic    req_credit_o;
  logic    res_valid_o;
  word_t   res_result_o;
  logic    res_branch_taken_o;
  logic    res_credit_i;

  logic [31:0]   rng = 32'd62;
  logic [31:0]   cycle_cnt = '0;
  int unsigned   up_credits;
  int unsigned   owed;
  int unsigned   sent_count;
  int unsigned   wait_cycles;
  logic [XLEN:0] expected_q[$];
  logic [XLEN:0] expected;

  alu_top #(
    .QUEUE_DEPTH(QUEUE_DEPTH),
    .OUT_CREDITS(OUT_CREDITS)
  ) dut_i (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .req_valid_i       (req_valid_i),
    .req_op_i          (req_op_i),
    .req_operand_a_i   (req_operand_a_i),
    .req_operand_b_i   (req_operand_b_i),
    .req_credit_o      (req_credit_o),
    .res_valid_o       (res_valid_o),
    .res_result_o      (res_result_o),
    .res_branch_taken_o(res_branch_taken_o),
    .res_credit_i      (res_credit_i)
  );

  bind alu_top alu_assertions #(
    .QUEUE_DEPTH(QUEUE_DEPTH),
    .OUT_CREDITS(OUT_CREDITS)
  ) u_assertions (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_credit_i(req_credit_o),
    .res_valid_i (res_valid_o),
    .res_credit_i(res_credit_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // Random source and reference model
  // --------------------------------------------------
  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Zero, all ones, small signed values or a full random word
  function automatic word_t pick_operand(logic [31:0] sel, logic [31:0] value);
    case (sel[2:0])
      3'd0:    return '0;
      3'd1:    return '1;
      3'd2:    return {{27{value[31]}}, value[4:0]};
      default: return value;
    endcase
  endfunction

  function automatic logic [XLEN:0] model_result(alu_op_e op, word_t a, word_t b);
    word_t      r;
    logic       taken;
    logic [5:0] sh;
    logic [5:0] n;
    r     = '0;
    taken = 1'b0;
    sh    = {1'b0, b[SHAMT_W-1:0]};
    n     = '0;
    case (op)
      ADD:   r = a + b;
      SUB:   r = a - b;
      ANDL:  r = a & b;
      ORL:   r = a | b;
      XORL:  r = a ^ b;
      ANDN:  r = a & ~b;
      ORN:   r = a | ~b;
      XNOR:  r = ~(a ^ b);
      SLL:   r = a << sh;
      SRL:   r = a >> sh;
      SRA:   r = word_t'($signed(a) >>> sh);
      ROL:   r = (a << sh) | (a >> (6'd32 - sh));
      ROR:   r = (a >> sh) | (a << (6'd32 - sh));
      SLTS:  r = word_t'($signed(a) < $signed(b));
      SLTU:  r = word_t'(a < b);
      MIN:   r = ($signed(a) < $signed(b)) ? a : b;
      MAX:   r = ($signed(a) < $signed(b)) ? b : a;
      MINU:  r = (a < b) ? a : b;
      MAXU:  r = (a < b) ? b : a;
      CLZ: begin
        for (int i = XLEN - 1; i >= 0 && !a[i]; i--) n++;
        r = word_t'(n);
      end
      CTZ: begin
        for (int i = 0; i < XLEN && !a[i]; i++) n++;
        r = word_t'(n);
      end
      CPOP: begin
        for (int i = 0; i < XLEN; i++) n = n + 6'(a[i]);
        r = word_t'(n);
      end
      SEXTB: r = {{24{a[7]}}, a[7:0]};
      SEXTH: r = {{16{a[15]}}, a[15:0]};
      ZEXTH: r = {16'd0, a[15:0]};
      ORCB: begin
        // Any set bit fills its byte with ones
        for (int i = 0; i < 4; i++) begin
          r[8*i +: 8] = (a[8*i +: 8] != 8'h00) ? 8'hff : 8'h00;
        end
      end
      REV8:  r = {a[7:0], a[15:8], a[23:16], a[31:24]};
      EQ:    taken = (a == b);
      NE:    taken = (a != b);
      LTS:   taken = $signed(a) < $signed(b);
      LTU:   taken = a < b;
      GES:   taken = $signed(a) >= $signed(b);
      GEU:   taken = a >= b;
      default: ;
    endcase
    return {taken, r};
  endfunction

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("Something failed");
    $fatal(1);
  endtask

  // --------------------------------------------------
  // One clock of stimulus
  // --------------------------------------------------
  task automatic step_cycle(bit allow_send);
    logic [31:0] ctl;
    alu_op_e     op;
    word_t       a;
    word_t       b;
    @(posedge clk_i);
    cycle_cnt = cycle_cnt + 1;
    ctl = next_rand();
    // Every fourth stretch of 32 cycles downstream holds its credits back
    if (owed != 0 && cycle_cnt[6:5] != 2'b11 && ctl[0]) begin
      res_credit_i <= 1'b1;
      owed--;
    end else begin
      res_credit_i <= 1'b0;
    end
    if (allow_send && up_credits != 0 && (ctl[1] | ctl[2])) begin
      op = alu_op_e'(6'(next_rand() % 33));
      a  = pick_operand(next_rand(), next_rand());
      b  = pick_operand(next_rand(), next_rand());
      // Equal operands now and then for the branch compares
      if (ctl[5:3] == 3'd0) begin
        b = a;
      end
      req_valid_i     <= 1'b1;
      req_op_i        <= op;
      req_operand_a_i <= a;
      req_operand_b_i <= b;
      expected_q.push_back(model_result(op, a, b));
      up_credits--;
      sent_count++;
      wait_cycles = 0;
    end else begin
      req_valid_i <= 1'b0;
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (dut_i.u_assertions.any_failure) begin
      abort_run("A protocol assertion failed");
    end
    if (rst_n_i) begin
      if (req_credit_o) begin
        up_credits++;
      end
      if (res_valid_o) begin
        owed++;
        if (expected_q.size() == 0) begin
          abort_run("A result came out with no request outstanding");
        end else begin
          expected = expected_q.pop_front();
          assert (res_result_o === expected[XLEN-1:0])
            else abort_run($sformatf("** Error res_result_o: got %h, expected %h",
                                     res_result_o, expected[XLEN-1:0]));
          assert (res_branch_taken_o === expected[XLEN])
            else abort_run($sformatf("** Error res_branch_taken_o: got %h, expected %h",
                                     res_branch_taken_o, expected[XLEN]));
        end
      end
    end
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    rst_n_i         = 1'b0;
    req_valid_i     = 1'b0;
    req_op_i        = ADD;
    req_operand_a_i = '0;
    req_operand_b_i = '0;
    res_credit_i    = 1'b0;
    up_credits      = QUEUE_DEPTH;
    owed            = 0;
    sent_count      = 0;
    wait_cycles     = 0;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    while (sent_count < NUM_REQS) begin
      step_cycle(1'b1);
      wait_cycles++;
      if (wait_cycles > TIMEOUT) begin
        abort_run("Timeout, no upstream credit came back");
      end
    end
    // Drain with credits still returned at random
    wait_cycles = 0;
    while (expected_q.size() != 0) begin
      step_cycle(1'b0);
      wait_cycles++;
      if (wait_cycles > TIMEOUT) begin
        abort_run("Timeout, results still missing after the last request");
      end
    end
    // Assertions of the last rising edge have reported by now
    @(negedge clk_i);
    if (!dut_i.u_assertions.any_failure) begin
      $display("Everything OK");
      $finish;
    end else begin
      abort_run("A protocol assertion failed");
    end
  end

endmodule

`default_nettype wire

//--- dv/alu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module alu_assertions #(
  parameter int unsigned QUEUE_DEPTH = 4,
  parameter int unsigned OUT_CREDITS = 2
) (
  input logic clk_i,
  input logic rst_n_i,
  input logic req_valid_i,
  input logic req_credit_i,
  input logic res_valid_i,
  input logic res_credit_i
);

  // Credits held by upstream and by the DUT toward downstream
  int unsigned up_cnt;
  int unsigned down_cnt;
  logic        sent_q;

  logic idle_fail   = 1'b0;
  logic res_fail    = 1'b0;
  logic pulse_fail  = 1'b0;
  logic bound_fail  = 1'b0;
  logic any_failure;

  assign any_failure = idle_fail | res_fail | pulse_fail | bound_fail;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      up_cnt   <= QUEUE_DEPTH;
      down_cnt <= OUT_CREDITS;
      sent_q   <= 1'b0;
    end else begin
      up_cnt   <= up_cnt + 32'(req_credit_i) - 32'(req_valid_i);
      down_cnt <= down_cnt + 32'(res_credit_i) - 32'(res_valid_i);
      if (req_valid_i) begin
        sent_q <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Protocol properties
  // --------------------------------------------------
  a_idle_after_reset: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !sent_q |-> (!res_valid_i && !req_credit_i))
    else begin
      $error("result or credit before any request");
      idle_fail = 1'b1;
    end

  a_result_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_valid_i |-> (down_cnt != 0 || res_credit_i))
    else begin
      $error("result sent without a downstream credit");
      res_fail = 1'b1;
    end

  a_credit_with_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_credit_i |-> res_valid_i)
    else begin
      $error("upstream credit returned without a result");
      pulse_fail = 1'b1;
    end

  a_upstream_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    up_cnt <= QUEUE_DEPTH)
    else begin
      $error("upstream credits above queue depth");
      bound_fail = 1'b1;
    end

endmodule

`default_nettype wire

//--- rtl/alu_top.sv
`timescale 1ns/1ps
`default_nettype none

module alu_top #(
  parameter int unsigned QUEUE_DEPTH = 4,
  parameter int unsigned OUT_CREDITS = 2
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             req_valid_i,
  input  alu_pkg::alu_op_e req_op_i,
  input  alu_pkg::word_t   req_operand_a_i,
  input  alu_pkg::word_t   req_operand_b_i,
  output logic             req_credit_o,
  output logic             res_valid_o,
  output alu_pkg::word_t   res_result_o,
  output logic             res_branch_taken_o,
  input  logic             res_credit_i
);

  import alu_pkg::*;

  // Stage 1
  logic    s1_valid;
  alu_op_e s1_op;
  word_t   s1_operand_a;
  word_t   s1_operand_b;
  logic    s1_negate_b;
  logic    s1_signed_cmp;
  logic    s1_shift_left;

  // Stage 2
  logic    s2_valid;
  word_t   s2_result;
  logic    s2_branch_taken;

  alu_op_issue u_issue (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_valid_i    (req_valid_i),
    .req_op_i       (req_op_i),
    .req_operand_a_i(req_operand_a_i),
    .req_operand_b_i(req_operand_b_i),
    .s1_valid_o     (s1_valid),
    .s1_op_o        (s1_op),
    .s1_operand_a_o (s1_operand_a),
    .s1_operand_b_o (s1_operand_b),
    .s1_negate_b_o  (s1_negate_b),
    .s1_signed_cmp_o(s1_signed_cmp),
    .s1_shift_left_o(s1_shift_left)
  );

  alu_exec u_exec (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .s1_valid_i       (s1_valid),
    .s1_op_i          (s1_op),
    .s1_operand_a_i   (s1_operand_a),
    .s1_operand_b_i   (s1_operand_b),
    .s1_negate_b_i    (s1_negate_b),
    .s1_signed_cmp_i  (s1_signed_cmp),
    .s1_shift_left_i  (s1_shift_left),
    .s2_valid_o       (s2_valid),
    .s2_result_o      (s2_result),
    .s2_branch_taken_o(s2_branch_taken)
  );

  alu_result_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH),
    .OUT_CREDITS(OUT_CREDITS)
  ) u_result_queue (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .s2_valid_i        (s2_valid),
    .s2_result_i       (s2_result),
    .s2_branch_taken_i (s2_branch_taken),
    .res_credit_i      (res_credit_i),
    .res_valid_o       (res_valid_o),
    .res_result_o      (res_result_o),
    .res_branch_taken_o(res_branch_taken_o),
    .req_credit_o      (req_credit_o)
  );

endmodule

`default_nettype wire

//--- rtl/alu_result_queue.sv
`timescale 1ns/1ps
`default_nettype none

module alu_result_queue #(
  parameter int unsigned QUEUE_DEPTH = 4,
  parameter int unsigned OUT_CREDITS = 2
) (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           s2_valid_i,
  input  alu_pkg::word_t s2_result_i,
  input  logic           s2_branch_taken_i,
  input  logic           res_credit_i,
  output logic           res_valid_o,
  output alu_pkg::word_t res_result_o,
  output logic           res_branch_taken_o,
  output logic           req_credit_o
);

  import alu_pkg::*;

  localparam int unsigned PTR_W  = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int unsigned FILL_W = $clog2(QUEUE_DEPTH + 1);
  localparam int unsigned CRED_W = $clog2(OUT_CREDITS + 2);

  word_t             result_mem [QUEUE_DEPTH];
  logic              branch_mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [FILL_W-1:0] fill_q;
  logic [CRED_W-1:0] credit_q;
  logic              empty;
  logic              credit_avail;
  logic              pop;

  // --------------------------------------------------
  // Pop decision
  // --------------------------------------------------
  assign empty        = (fill_q == '0);
  // A credit arriving this cycle can be spent at once
  assign credit_avail = (credit_q != '0) || res_credit_i;
  assign pop          = !empty && credit_avail;

  assign res_valid_o        = pop;
  assign res_result_o       = result_mem[rd_ptr_q];
  assign res_branch_taken_o = branch_mem[rd_ptr_q];
  // Freed slot goes straight back upstream
  assign req_credit_o       = pop;

  // Storage, write side only
  always_ff @(posedge clk_i) begin
    if (s2_valid_i) begin
      result_mem[wr_ptr_q] <= s2_result_i;
      branch_mem[wr_ptr_q] <= s2_branch_taken_i;
    end
  end

  // --------------------------------------------------
  // Pointers, fill level and downstream credits
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
      credit_q <= CRED_W'(OUT_CREDITS);
    end else begin
      if (s2_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({s2_valid_i, pop})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: ;
      endcase
      case ({res_credit_i, pop})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/alu_exec.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             s1_valid_i,
  input  alu_pkg::alu_op_e s1_op_i,
  input  alu_pkg::word_t   s1_operand_a_i,
  input  alu_pkg::word_t   s1_operand_b_i,
  input  logic             s1_negate_b_i,
  input  logic             s1_signed_cmp_i,
  input  logic             s1_shift_left_i,
  output logic             s2_valid_o,
  output alu_pkg::word_t   s2_result_o,
  output logic             s2_branch_taken_o
);

  import alu_pkg::*;

  logic [XLEN:0] adder_in_a;
  logic [XLEN:0] adder_in_b;
  logic [XLEN:0] adder_sum;
  word_t         adder_result;
  word_t         operand_b_inv;
  logic          zero_flag;
  logic [XLEN:0] cmp_a;
  logic [XLEN:0] cmp_b;
  logic          less;
  word_t         shift_result;
  cnt_t          zero_count;
  cnt_t          pop_count;
  word_t         orcb_result;
  word_t         rev8_result;
  word_t         result;
  logic          branch_taken;

  // --------------------------------------------------
  // Adder and flags
  // --------------------------------------------------

  // Low bit of a is 1 so the inverted b gets its +1 for subtraction
  assign adder_in_a    = {s1_operand_a_i, 1'b1};
  assign adder_in_b    = {s1_operand_b_i, 1'b0} ^ {(XLEN + 1){s1_negate_b_i}};
  assign adder_sum     = adder_in_a + adder_in_b;
  assign adder_result  = adder_sum[XLEN:1];
  assign operand_b_inv = adder_in_b[XLEN:1];
  assign zero_flag     = ~|adder_result;

  // One comparator for both signed and unsigned
  assign cmp_a = {s1_signed_cmp_i & s1_operand_a_i[XLEN-1], s1_operand_a_i};
  assign cmp_b = {s1_signed_cmp_i & s1_operand_b_i[XLEN-1], s1_operand_b_i};
  assign less  = $signed(cmp_a) < $signed(cmp_b);

  // --------------------------------------------------
  // Shifter and counts
  // --------------------------------------------------
  alu_shifter u_shifter (
    .operand_a_i (s1_operand_a_i),
    .shamt_i     (s1_operand_b_i[SHAMT_W-1:0]),
    .shift_left_i(s1_shift_left_i),
    .arithmetic_i(s1_op_i == SRA),
    .rotate_i    (s1_op_i inside {ROL, ROR}),
    .result_o    (shift_result)
  );

  alu_bit_count u_bit_count (
    .operand_i   (s1_operand_a_i),
    .trailing_i  (s1_op_i == CTZ),
    .zero_count_o(zero_count),
    .pop_count_o (pop_count)
  );

  // Byte-wise OR-combine and byte swap
  always_comb begin
    for (int i = 0; i < XLEN / 8; i++) begin
      orcb_result[8*i +: 8] = {8{|s1_operand_a_i[8*i +: 8]}};
      rev8_result[8*i +: 8] = s1_operand_a_i[XLEN-8-8*i +: 8];
    end
  end

  // --------------------------------------------------
  // Result mux and branch resolution
  // --------------------------------------------------
  always_comb begin
    result       = '0;
    branch_taken = 1'b0;
    unique case (s1_op_i)
      ADD, SUB:               result = adder_result;
      ANDL, ANDN:             result = s1_operand_a_i & operand_b_inv;
      ORL, ORN:               result = s1_operand_a_i | operand_b_inv;
      XORL, XNOR:             result = s1_operand_a_i ^ operand_b_inv;
      SLL, SRL, SRA, ROL, ROR: result = shift_result;
      SLTS, SLTU:             result = {{(XLEN - 1){1'b0}}, less};
      MIN, MINU:              result = less ? s1_operand_a_i : s1_operand_b_i;
      MAX, MAXU:              result = less ? s1_operand_b_i : s1_operand_a_i;
      CLZ, CTZ:               result = {{(XLEN - CNT_W){1'b0}}, zero_count};
      CPOP:                   result = {{(XLEN - CNT_W){1'b0}}, pop_count};
      SEXTB:  result = {{(XLEN - 8){s1_operand_a_i[7]}}, s1_operand_a_i[7:0]};
      SEXTH:  result = {{(XLEN - 16){s1_operand_a_i[15]}}, s1_operand_a_i[15:0]};
      ZEXTH:  result = {{(XLEN - 16){1'b0}}, s1_operand_a_i[15:0]};
      ORCB:   result = orcb_result;
      REV8:   result = rev8_result;
      // Branches leave the result at zero
      EQ:       branch_taken = zero_flag;
      NE:       branch_taken = ~zero_flag;
      LTS, LTU: branch_taken = less;
      GES, GEU: branch_taken = ~less;
      default: ;
    endcase
  end

  // --------------------------------------------------
  // Stage 2 register
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s2_valid_o <= 1'b0;
    end else begin
      s2_valid_o <= s1_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_valid_i) begin
      s2_result_o       <= result;
      s2_branch_taken_o <= branch_taken;
    end
  end

endmodule

`default_nettype wire

//--- rtl/alu_bit_count.sv
`timescale 1ns/1ps
`default_nettype none

module alu_bit_count (
  input  alu_pkg::word_t operand_i,
  input  logic           trailing_i,
  output alu_pkg::cnt_t  zero_count_o,
  output alu_pkg::cnt_t  pop_count_o
);

  import alu_pkg::*;

  word_t scan;

  // Trailing zeros are leading zeros of the reversed word
  assign scan = trailing_i ? bit_reverse(operand_i) : operand_i;

  // --------------------------------------------------
  // Leading zeros
  // --------------------------------------------------
  always_comb begin
    // All-zero word keeps the full width
    zero_count_o = cnt_t'(XLEN);
    // Highest set bit is the last one to write
    for (int i = 0; i < XLEN; i++) begin
      if (scan[i]) begin
        zero_count_o = cnt_t'(XLEN - 1 - i);
      end
    end
  end

  // --------------------------------------------------
  // Population count
  // --------------------------------------------------
  always_comb begin
    pop_count_o = '0;
    for (int i = 0; i < XLEN; i++) begin
      pop_count_o = pop_count_o + cnt_t'(operand_i[i]);
    end
  end

endmodule

`default_nettype wire

//--- rtl/alu_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module alu_shifter (
  input  alu_pkg::word_t  operand_a_i,
  input  alu_pkg::shamt_t shamt_i,
  input  logic            shift_left_i,
  input  logic            arithmetic_i,
  input  logic            rotate_i,
  output alu_pkg::word_t  result_o
);

  import alu_pkg::*;

  localparam logic [SHAMT_W:0] FULL_AMT = (SHAMT_W + 1)'(XLEN);

  word_t            shift_in;
  logic [XLEN:0]    shift_ext;
  logic [XLEN:0]    right_ext;
  logic [SHAMT_W:0] comp_amt;
  word_t            wrap_bits;
  word_t            right_res;

  // Left operations run through the right shifter reversed
  assign shift_in = shift_left_i ? bit_reverse(operand_a_i) : operand_a_i;

  // Extra top bit carries the sign for SRA
  assign shift_ext = {arithmetic_i & shift_in[XLEN-1], shift_in};
  assign right_ext = $unsigned($signed(shift_ext) >>> shamt_i);

  // Complementary left shift, zero when the amount is zero
  assign comp_amt  = FULL_AMT - {1'b0, shamt_i};
  assign wrap_bits = rotate_i ? (shift_in << comp_amt) : '0;

  assign right_res = right_ext[XLEN-1:0] | wrap_bits;

  // Undo the reversal for SLL and ROL
  assign result_o = shift_left_i ? bit_reverse(right_res) : right_res;

endmodule

`default_nettype wire

//--- rtl/alu_op_issue.sv
`timescale 1ns/1ps
`default_nettype none

module alu_op_issue (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             req_valid_i,
  input  alu_pkg::alu_op_e req_op_i,
  input  alu_pkg::word_t   req_operand_a_i,
  input  alu_pkg::word_t   req_operand_b_i,
  output logic             s1_valid_o,
  output alu_pkg::alu_op_e s1_op_o,
  output alu_pkg::word_t   s1_operand_a_o,
  output alu_pkg::word_t   s1_operand_b_o,
  output logic             s1_negate_b_o,
  output logic             s1_signed_cmp_o,
  output logic             s1_shift_left_o
);

  import alu_pkg::*;

  logic negate_b;
  logic signed_cmp;
  logic shift_left;

  // --------------------------------------------------
  // Control decode
  // --------------------------------------------------

  // Operand b goes through the adder inverted
  assign negate_b = req_op_i inside {SUB, EQ, NE, ANDN, ORN, XNOR};

  // Compare with sign extension of both operands
  assign signed_cmp = req_op_i inside {SLTS, LTS, GES, MIN, MAX};

  // Left direction, shifter reverses the operand
  assign shift_left = req_op_i inside {SLL, ROL};

  // --------------------------------------------------
  // Stage 1 register
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid_o <= 1'b0;
    end else begin
      s1_valid_o <= req_valid_i;
    end
  end

  // Payload only loads on an accepted request
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      s1_op_o         <= req_op_i;
      s1_operand_a_o  <= req_operand_a_i;
      s1_operand_b_o  <= req_operand_b_i;
      s1_negate_b_o   <= negate_b;
      s1_signed_cmp_o <= signed_cmp;
      s1_shift_left_o <= shift_left;
    end
  end

endmodule

`default_nettype wire

//--- rtl/alu_pkg.sv
`default_nettype none

package alu_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int unsigned XLEN = 32;
  localparam int unsigned SHAMT_W = $clog2(XLEN);
  // Must hold the value XLEN itself
  localparam int unsigned CNT_W = $clog2(XLEN) + 1;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [SHAMT_W-1:0] shamt_t;
  typedef logic [CNT_W-1:0] cnt_t;

  // --------------------------------------------------
  // Operations
  // --------------------------------------------------
  typedef enum logic [5:0] {
    // Arithmetic and logic
    ADD, SUB, ANDL, ORL, XORL, ANDN, ORN, XNOR,
    // Shifts and rotates
    SLL, SRL, SRA, ROL, ROR,
    // Set-less-than and min/max
    SLTS, SLTU, MIN, MAX, MINU, MAXU,
    // Bit counts
    CLZ, CTZ, CPOP,
    // Byte handling and extensions
    SEXTB, SEXTH, ZEXTH, ORCB, REV8,
    // Branch compares
    EQ, NE, LTS, LTU, GES, GEU
  } alu_op_e;

  // Bit 0 swaps with bit XLEN-1 and so on
  function automatic word_t bit_reverse(word_t value);
    word_t rev;
    for (int i = 0; i < XLEN; i++) begin
      rev[i] = value[XLEN-1-i];
    end
    return rev;
  endfunction

endpackage

`default_nettype wire
